//--- common/i2c_sender_cfg.svh
`ifndef I2C_SENDER_CFG_SVH
`define I2C_SENDER_CFG_SVH

// upper address nibble of the i2c block
`define SB_BASE      4'b0001

// register offsets inside the block
`define REG_CR1      4'd1
`define REG_BRLSB    4'd2
`define REG_BRMSB    4'd3
`define REG_IRQEN    4'd5
`define REG_CMDR     4'd7
`define REG_TXDR     4'd8
`define REG_SR       4'd11

// setup values, written once after reset
`define SETUP_CR1    8'h80
`define SETUP_BRLSB  8'd120
`define SETUP_BRMSB  8'd0
`define SETUP_IRQEN  8'h06

// status register bits
`define SR_BUSY      8'h40
`define SR_TRRDY     8'h04
`define SR_NACK      8'h02

// command register values
`define CMD_WRITE    8'h94
`define CMD_STOP     8'h44

// 7-bit target, sent shifted left with a 0 write bit
`define DEV_ADDR     7'h23

// table sizes
`define NUM_SETUP    4
`define NUM_XFERS    4
`define XFER_BYTES   3

`endif

//--- common/i2c_sender_pkg.sv
package i2c_sender_pkg;

    // system bus payload
    typedef logic [7:0] sb_addr_t;
    typedef logic [7:0] sb_data_t;

    typedef enum logic {
        SB_READ  = 1'b0,
        SB_WRITE = 1'b1
    } sb_dir_t;

    // bus controller states
    typedef enum logic [1:0] {
        SBC_IDLE,
        SBC_SETUP,
        SBC_STROBE
    } sbc_state_t;

    // sequencer states
    typedef enum logic [2:0] {
        SEQ_SETUP,
        SEQ_WAIT_IDLE,
        SEQ_TXDR,
        SEQ_CMDR,
        SEQ_POLL,
        SEQ_STOP,
        SEQ_FINISHED
    } seq_state_t;

endpackage

//--- source/system_bus_controller.sv
`timescale 1ns/1ps

module system_bus_controller import i2c_sender_pkg::*; (
    input  logic     clock,
    input  logic     reset,

    // request from the sequencer
    input  logic     req,
    input  sb_dir_t  req_dir,
    input  sb_addr_t req_addr,
    input  sb_data_t req_wdata,
    output logic     done,
    output sb_data_t rdata,

    // system bus to the i2c block
    input  logic     sback,
    input  sb_data_t sbdat_in,
    output logic     sbstb,
    output sb_dir_t  sbrw,
    output sb_addr_t sbadr,
    output sb_data_t sbdat_out
);

    sbc_state_t state;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= SBC_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                SBC_IDLE: begin
                    if (req) begin
                        state <= SBC_SETUP;
                    end
                end
                // one cycle of address setup before the strobe
                SBC_SETUP: begin
                    state <= SBC_STROBE;
                end
                SBC_STROBE: begin
                    if (sback) begin
                        state <= SBC_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= SBC_IDLE;
                end
            endcase
        end
    end

    // bus payload held from latch until the next request
    always_ff @(posedge clock) begin
        if (state == SBC_IDLE && req) begin
            sbrw      <= req_dir;
            sbadr     <= req_addr;
            sbdat_out <= req_wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (state == SBC_STROBE && sback && sbrw == SB_READ) begin
            rdata <= sbdat_in;
        end
    end

    assign sbstb = (state == SBC_STROBE);

    // sequencer must wait for done before the next request
    a_req_only_idle: assert property (@(posedge clock) disable iff (!reset)
        req |-> state == SBC_IDLE);

    // bus signals frozen until the peripheral acknowledges
    a_bus_stable: assert property (@(posedge clock) disable iff (!reset)
        sbstb && !sback |=> sbstb && $stable(sbadr) && $stable(sbrw) && $stable(sbdat_out));

endmodule

//--- source/i2c_sequencer.sv
`timescale 1ns/1ps

`include "i2c_sender_cfg.svh"

module i2c_sequencer import i2c_sender_pkg::*; (
    input  logic     clock,
    input  logic     reset,

    // completion from the bus controller
    input  logic     done,
    input  sb_data_t rdata,

    // request to the bus controller
    output logic     req,
    output sb_dir_t  req_dir,
    output sb_addr_t req_addr,
    output sb_data_t req_wdata,

    output logic     finished,
    output logic     nack_error
);

    localparam int setup_w = $clog2(`NUM_SETUP);
    localparam int xfer_w  = $clog2(`NUM_XFERS);
    localparam int byte_w  = $clog2(`XFER_BYTES);

    localparam logic [setup_w-1:0] last_setup = setup_w'(`NUM_SETUP - 1);
    localparam logic [xfer_w-1:0]  last_xfer  = xfer_w'(`NUM_XFERS - 1);
    localparam logic [byte_w-1:0]  last_byte  = byte_w'(`XFER_BYTES - 1);

    seq_state_t         state;
    seq_state_t         state_n;
    logic [setup_w-1:0] setup_idx;
    logic [setup_w-1:0] setup_idx_n;
    logic [xfer_w-1:0]  xfer_idx;
    logic [xfer_w-1:0]  xfer_idx_n;
    logic [byte_w-1:0]  byte_cnt;
    logic [byte_w-1:0]  byte_cnt_n;
    logic               nack_n;
    logic               kick;
    logic               issue;

    logic [3:0]         setup_off;
    sb_data_t           setup_val;
    sb_dir_t            dir_n;
    sb_addr_t           addr_n;
    sb_data_t           wdata_n;

    // setup table as {offset, value}
    function automatic logic [11:0] setup_entry(input logic [setup_w-1:0] idx);
        case (idx)
            setup_w'(0): setup_entry = {`REG_CR1, `SETUP_CR1};
            setup_w'(1): setup_entry = {`REG_BRLSB, `SETUP_BRLSB};
            setup_w'(2): setup_entry = {`REG_BRMSB, `SETUP_BRMSB};
            default:     setup_entry = {`REG_IRQEN, `SETUP_IRQEN};
        endcase
    endfunction

    // address byte, then index, then index squared
    function automatic sb_data_t xfer_byte(input logic [xfer_w-1:0] idx,
                                           input logic [byte_w-1:0] sel);
        sb_data_t val;
        val = sb_data_t'(idx);
        if (sel == '0) begin
            xfer_byte = {`DEV_ADDR, 1'b0};
        end else if (sel == byte_w'(1)) begin
            xfer_byte = val;
        end else begin
            xfer_byte = val * val;
        end
    endfunction

    always_comb begin
        state_n     = state;
        setup_idx_n = setup_idx;
        xfer_idx_n  = xfer_idx;
        byte_cnt_n  = byte_cnt;
        nack_n      = nack_error;
        if (done) begin
            case (state)
                SEQ_SETUP: begin
                    if (setup_idx == last_setup) begin
                        state_n = SEQ_WAIT_IDLE;
                    end else begin
                        setup_idx_n = setup_idx + 1'b1;
                    end
                end
                SEQ_WAIT_IDLE: begin
                    if ((rdata & `SR_BUSY) == '0) begin
                        state_n    = SEQ_TXDR;
                        byte_cnt_n = '0;
                    end
                end
                SEQ_TXDR: begin
                    state_n = SEQ_CMDR;
                end
                SEQ_CMDR: begin
                    state_n = SEQ_POLL;
                end
                // nack wins over trrdy
                SEQ_POLL: begin
                    if ((rdata & `SR_NACK) != '0) begin
                        state_n = SEQ_STOP;
                        nack_n  = 1'b1;
                    end else if ((rdata & `SR_TRRDY) != '0) begin
                        if (byte_cnt == last_byte) begin
                            state_n = SEQ_STOP;
                        end else begin
                            state_n    = SEQ_TXDR;
                            byte_cnt_n = byte_cnt + 1'b1;
                        end
                    end
                end
                SEQ_STOP: begin
                    if (nack_error || xfer_idx == last_xfer) begin
                        state_n = SEQ_FINISHED;
                    end else begin
                        state_n    = SEQ_WAIT_IDLE;
                        xfer_idx_n = xfer_idx + 1'b1;
                    end
                end
                default: begin
                    state_n = SEQ_FINISHED;
                end
            endcase
        end
    end

    assign issue = (kick || done) && state_n != SEQ_FINISHED;

    assign {setup_off, setup_val} = setup_entry(setup_idx_n);

    // payload for the state about to be entered
    always_comb begin
        dir_n   = SB_WRITE;
        addr_n  = {`SB_BASE, `REG_SR};
        wdata_n = '0;
        case (state_n)
            SEQ_SETUP: begin
                addr_n  = {`SB_BASE, setup_off};
                wdata_n = setup_val;
            end
            SEQ_WAIT_IDLE, SEQ_POLL: begin
                dir_n = SB_READ;
            end
            SEQ_TXDR: begin
                addr_n  = {`SB_BASE, `REG_TXDR};
                wdata_n = xfer_byte(xfer_idx_n, byte_cnt_n);
            end
            SEQ_CMDR: begin
                addr_n  = {`SB_BASE, `REG_CMDR};
                wdata_n = `CMD_WRITE;
            end
            SEQ_STOP: begin
                addr_n  = {`SB_BASE, `REG_CMDR};
                wdata_n = `CMD_STOP;
            end
            default: begin
                dir_n = SB_READ;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= SEQ_SETUP;
            setup_idx  <= '0;
            xfer_idx   <= '0;
            byte_cnt   <= '0;
            nack_error <= 1'b0;
            kick       <= 1'b1;
            req        <= 1'b0;
        end else begin
            state      <= state_n;
            setup_idx  <= setup_idx_n;
            xfer_idx   <= xfer_idx_n;
            byte_cnt   <= byte_cnt_n;
            nack_error <= nack_n;
            kick       <= 1'b0;
            req        <= issue;
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            req_dir   <= dir_n;
            req_addr  <= addr_n;
            req_wdata <= wdata_n;
        end
    end

    assign finished = (state == SEQ_FINISHED);

    a_no_req_finished: assert property (@(posedge clock) disable iff (!reset)
        state == SEQ_FINISHED |-> !req);

endmodule

//--- source/i2c_sender_top.sv
`timescale 1ns/1ps

module i2c_sender_top import i2c_sender_pkg::*; (
    input  logic     clock,
    input  logic     reset,

    input  logic     sback,
    input  sb_data_t sbdat_in,
    output logic     sbstb,
    output sb_dir_t  sbrw,
    output sb_addr_t sbadr,
    output sb_data_t sbdat_out,

    output logic     finished,
    output logic     nack_error
);

    logic     req;
    sb_dir_t  req_dir;
    sb_addr_t req_addr;
    sb_data_t req_wdata;
    logic     done;
    sb_data_t rdata;

    i2c_sequencer u_sequencer (
        .clock      (clock),
        .reset      (reset),
        .done       (done),
        .rdata      (rdata),
        .req        (req),
        .req_dir    (req_dir),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .finished   (finished),
        .nack_error (nack_error)
    );

    system_bus_controller u_bus_controller (
        .clock     (clock),
        .reset     (reset),
        .req       (req),
        .req_dir   (req_dir),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .done      (done),
        .rdata     (rdata),
        .sback     (sback),
        .sbdat_in  (sbdat_in),
        .sbstb     (sbstb),
        .sbrw      (sbrw),
        .sbadr     (sbadr),
        .sbdat_out (sbdat_out)
    );

endmodule

//--- verif/sb_peripheral_model.sv
`timescale 1ns/1ps

`include "i2c_sender_cfg.svh"

module sb_peripheral_model import i2c_sender_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     sbstb,
    input  sb_dir_t  sbrw,
    input  sb_addr_t sbadr,
    input  sb_data_t sbdat_out,
    // transfer that gets a NACK, negative for none
    input  int       nack_xfer,
    output logic     sback,
    output sb_data_t sbdat_in
);

    localparam int log_depth = 256;

    sb_dir_t     log_rw   [log_depth];
    sb_addr_t    log_addr [log_depth];
    sb_data_t    log_data [log_depth];
    int          log_count;

    logic [31:0] rng;
    int          wait_cnt;
    int          busy_left;
    int          trrdy_left;
    int          xfer_cnt;
    int          cmd_cnt;
    logic        nack_pending;
    sb_data_t    status;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int next_rand(input int span);
        rng = xorshift(rng);
        return int'(rng % span);
    endfunction

    task automatic record(input sb_dir_t rw, input sb_addr_t adr, input sb_data_t dat);
        if (log_count < log_depth) begin
            log_rw[log_count]   = rw;
            log_addr[log_count] = adr;
            log_data[log_count] = dat;
        end
        log_count++;
    endtask

    initial begin
        rng       = 32'h5b19;
        sback     = 1'b0;
        sbdat_in  = '0;
        log_count = 0;
    end

    always @(negedge clock) begin
        if (!reset) begin
            sback        <= 1'b0;
            wait_cnt     = -1;
            busy_left    = 0;
            trrdy_left   = 0;
            xfer_cnt     = 0;
            cmd_cnt      = 0;
            nack_pending = 1'b0;
            log_count    = 0;
        end else if (sback) begin
            sback <= 1'b0;
        end else if (sbstb) begin
            if (wait_cnt < 0) begin
                wait_cnt = next_rand(4);
            end
            if (wait_cnt > 0) begin
                wait_cnt--;
            end else begin
                wait_cnt = -1;
                sback    <= 1'b1;
                if (sbrw == SB_READ) begin
                    // status register model
                    status = '0;
                    if (busy_left > 0) begin
                        status = status | `SR_BUSY;
                        busy_left--;
                    end
                    if (trrdy_left > 0) begin
                        trrdy_left--;
                    end else begin
                        status = status | `SR_TRRDY;
                    end
                    if (nack_pending) begin
                        status       = status | `SR_NACK;
                        nack_pending = 1'b0;
                    end
                    sbdat_in <= status;
                    record(SB_READ, sbadr, status);
                end else begin
                    record(SB_WRITE, sbadr, sbdat_out);
                    if (sbadr == {`SB_BASE, `REG_CMDR} && sbdat_out == `CMD_WRITE) begin
                        trrdy_left   = next_rand(3);
                        nack_pending = (xfer_cnt == nack_xfer && cmd_cnt == 0);
                        cmd_cnt++;
                    end else if (sbadr == {`SB_BASE, `REG_CMDR} && sbdat_out == `CMD_STOP) begin
                        busy_left = next_rand(3);
                        xfer_cnt++;
                        cmd_cnt   = 0;
                    end
                end
            end
        end
    end

endmodule

//--- verif/tb_i2c_sender.sv
`timescale 1ns/1ps

`include "i2c_sender_cfg.svh"

module tb_i2c_sender import i2c_sender_pkg::*; ();

    localparam int clock_period = 40;
    // two runs of at most 200 bus cycles of 8 clocks each
    localparam int watchdog_ns  = 2 * 200 * 8 * clock_period;

    logic     clock;
    logic     reset;
    logic     sback;
    sb_data_t sbdat_in;
    logic     sbstb;
    sb_dir_t  sbrw;
    sb_addr_t sbadr;
    sb_data_t sbdat_out;
    logic     finished;
    logic     nack_error;
    int       nack_xfer;

    int       errors;
    int       tests_run;
    int       tests_failed;
    int       reset_edges;
    logic     prev_valid;
    logic     prev_stb;
    logic     prev_ack;
    sb_dir_t  prev_rw;
    sb_addr_t prev_adr;
    sb_data_t prev_dat;
    sb_data_t last_sr;

    i2c_sender_top u_dut (
        .clock      (clock),
        .reset      (reset),
        .sback      (sback),
        .sbdat_in   (sbdat_in),
        .sbstb      (sbstb),
        .sbrw       (sbrw),
        .sbadr      (sbadr),
        .sbdat_out  (sbdat_out),
        .finished   (finished),
        .nack_error (nack_error)
    );

    sb_peripheral_model u_periph (
        .clock     (clock),
        .reset     (reset),
        .sbstb     (sbstb),
        .sbrw      (sbrw),
        .sbadr     (sbadr),
        .sbdat_out (sbdat_out),
        .nack_xfer (nack_xfer),
        .sback     (sback),
        .sbdat_in  (sbdat_in)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(clock_period / 2);
            clock = ~clock;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the runs did not finish", watchdog_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic expect_value(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
            errors++;
        end
    endtask

    // skips status reads and keeps the last one
    task automatic next_write(inout int p, output sb_addr_t adr, output sb_data_t dat);
        adr = '0;
        dat = '0;
        while (p < u_periph.log_count && u_periph.log_rw[p] == SB_READ) begin
            last_sr = u_periph.log_data[p];
            p++;
        end
        if (p < u_periph.log_count) begin
            adr = u_periph.log_addr[p];
            dat = u_periph.log_data[p];
            p++;
        end else begin
            report_failure("bus log ended before an expected write");
        end
    endtask

    task automatic check_log(input int nack_at);
        sb_addr_t setup_adr [`NUM_SETUP];
        sb_data_t setup_dat [`NUM_SETUP];
        sb_addr_t adr;
        sb_data_t dat;
        sb_data_t rule_byte;
        logic     nacked;
        int       p;
        setup_adr = '{{`SB_BASE, `REG_CR1}, {`SB_BASE, `REG_BRLSB},
                      {`SB_BASE, `REG_BRMSB}, {`SB_BASE, `REG_IRQEN}};
        setup_dat = '{`SETUP_CR1, `SETUP_BRLSB, `SETUP_BRMSB, `SETUP_IRQEN};
        p       = 0;
        last_sr = '0;
        nacked  = 1'b0;
        for (int s = 0; s < `NUM_SETUP; s++) begin
            next_write(p, adr, dat);
            expect_value("setup sbadr", adr, setup_adr[s]);
            expect_value("setup sbdat_out", dat, setup_dat[s]);
        end
        for (int i = 0; i < `NUM_XFERS && !nacked; i++) begin
            for (int k = 0; k < `XFER_BYTES && !nacked; k++) begin
                if (k == 0) begin
                    rule_byte = {`DEV_ADDR, 1'b0};
                end else if (k == 1) begin
                    rule_byte = 8'(i);
                end else begin
                    rule_byte = 8'(i * i);
                end
                next_write(p, adr, dat);
                assert ((last_sr & `SR_BUSY) == '0) else
                    report_failure("TXDR write after a status read with BUSY set");
                expect_value("txdr sbadr", adr, {`SB_BASE, `REG_TXDR});
                expect_value("txdr sbdat_out", dat, rule_byte);
                assert (p < u_periph.log_count && u_periph.log_rw[p] == SB_WRITE) else
                    report_failure("status read between the TXDR write and its CMDR write");
                next_write(p, adr, dat);
                expect_value("cmdr sbadr", adr, {`SB_BASE, `REG_CMDR});
                expect_value("cmdr sbdat_out", dat, `CMD_WRITE);
                nacked = (i == nack_at && k == 0);
            end
            next_write(p, adr, dat);
            expect_value("stop sbadr", adr, {`SB_BASE, `REG_CMDR});
            expect_value("stop sbdat_out", dat, `CMD_STOP);
            if (nacked) begin
                assert ((last_sr & `SR_NACK) != '0) else
                    report_failure("stop written without NACK in the last status read");
            end
        end
        assert (p == u_periph.log_count) else
            report_failure("bus cycles after the final stop");
    endtask

    task automatic run_test(input string name, input int nack_at);
        int errors_before;
        errors_before = errors;
        reset     = 1'b0;
        nack_xfer = nack_at;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        while (!finished) begin
            @(negedge clock);
        end
        // idle time so a late strobe would show up
        repeat (20) @(negedge clock);
        expect_value("finished", 8'(finished), 8'h1);
        expect_value("nack_error", 8'(nack_error), 8'(nack_at >= 0));
        check_log(nack_at);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d errors", name,
                 (errors == errors_before) ? "ok" : "bad", errors - errors_before);
    endtask

    always @(posedge clock) begin
        // reset values during reset and on the first edge after release
        if (reset_edges > 0) begin
            expect_value("sbstb", 8'(sbstb), 8'h0);
            expect_value("finished", 8'(finished), 8'h0);
            expect_value("nack_error", 8'(nack_error), 8'h0);
        end
        reset_edges = reset ? 0 : reset_edges + 1;
        if (reset && prev_valid) begin
            if (prev_stb && !prev_ack) begin
                expect_value("sbstb", 8'(sbstb), 8'h1);
                expect_value("sbadr", sbadr, prev_adr);
                expect_value("sbrw", 8'(sbrw), 8'(prev_rw));
                expect_value("sbdat_out", sbdat_out, prev_dat);
            end
            if (prev_ack || finished) begin
                expect_value("sbstb", 8'(sbstb), 8'h0);
            end
        end
        prev_valid = reset;
        prev_stb   = sbstb;
        prev_ack   = sback;
        prev_rw    = sbrw;
        prev_adr   = sbadr;
        prev_dat   = sbdat_out;
    end

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_edges  = 0;
        prev_valid   = 1'b0;
        nack_xfer    = -1;
        reset        = 1'b0;
        run_test("no_nack", -1);
        run_test("nack_on_transfer_2", 2);
        $display("summary: tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/i2c_sender_pkg.sv
source/system_bus_controller.sv
source/i2c_sequencer.sv
source/i2c_sender_top.sv
verif/sb_peripheral_model.sv
verif/tb_i2c_sender.sv

//--- Bender.yml
package:
  name: i2c_sender

sources:
  - include_dirs:
      - common
    files:
      - common/i2c_sender_pkg.sv
      - source/system_bus_controller.sv
      - source/i2c_sequencer.sv
      - source/i2c_sender_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/sb_peripheral_model.sv
      - verif/tb_i2c_sender.sv
